// File: verilog/nn_cfg.svh
`ifndef NN_CFG_SVH
`define NN_CFG_SVH

// network shape
`define NN_LAYER_MAX        3
`define NN_NUM_NEURON       4
`define NN_LAYER_BITS       2

// input format, unsigned fixed point
`define NN_INPUT_SIZE       9
`define NN_INPUT_FRACTION   8

// weight format, signed fixed point
`define NN_WEIGHT_SIZE      17
`define NN_WEIGHT_FRACTION  8

// neuron output format and accumulator
`define NN_OUTPUT_SIZE      10
`define NN_FRACTION_BITS    6
`define NN_ACC_SIZE         32

`endif

// File: verilog/nn_pkg.sv
`default_nettype none

`include "nn_cfg.svh"

package nn_pkg;

    // scalar values
    typedef logic [`NN_INPUT_SIZE-1:0] in_val_t;
    typedef logic signed [`NN_WEIGHT_SIZE-1:0] weight_t;
    typedef logic [`NN_OUTPUT_SIZE-1:0] out_val_t;
    typedef logic [`NN_LAYER_BITS-1:0] layer_idx_t;

    // one value per neuron
    typedef in_val_t [`NN_NUM_NEURON-1:0] in_vec_t;
    typedef out_val_t [`NN_NUM_NEURON-1:0] out_vec_t;

    // weights of one neuron, indexed by input
    typedef weight_t [`NN_NUM_NEURON-1:0] weight_row_t;

endpackage

`default_nettype wire

// File: verilog/weight_memory.sv
`default_nettype none

`include "nn_cfg.svh"

module weight_memory (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 w_wr_en,
    input  wire nn_pkg::layer_idx_t w_layer,
    input  wire [1:0]           w_neuron,
    input  wire [1:0]           w_input,
    input  wire nn_pkg::weight_t w_data,
    input  wire nn_pkg::layer_idx_t layer_idx,
    output nn_pkg::weight_row_t [`NN_NUM_NEURON-1:0] layer_weights
);

    // layers by neurons, each entry a row over inputs
    nn_pkg::weight_row_t mem [`NN_LAYER_MAX][`NN_NUM_NEURON];

    // single weight write port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < `NN_LAYER_MAX; l++) begin
                for (int n = 0; n < `NN_NUM_NEURON; n++) begin
                    mem[l][n] <= '0;
                end
            end
        end else if (w_wr_en && (w_layer < `NN_LAYER_MAX)) begin
            // layer index 3 has no storage
            mem[w_layer][w_neuron][w_input] <= w_data;
        end
    end

    // whole matrix of the selected layer, no read latency
    always_comb begin
        for (int n = 0; n < `NN_NUM_NEURON; n++) begin
            if (layer_idx < `NN_LAYER_MAX) begin
                layer_weights[n] = mem[layer_idx][n];
            end else begin
                layer_weights[n] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/neuron.sv
`default_nettype none

`include "nn_cfg.svh"

module neuron (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  start,
    input  wire nn_pkg::in_vec_t inputs,
    input  wire nn_pkg::weight_row_t weights,
    output nn_pkg::out_val_t     out_value,
    output logic                 out_valid
);

    localparam int IDX_W   = $clog2(`NN_NUM_NEURON);
    localparam int STEP_W  = $clog2(`NN_NUM_NEURON + 1);
    // product carries input plus weight fraction, output keeps NN_FRACTION_BITS
    localparam int SHIFT   = `NN_INPUT_FRACTION + `NN_WEIGHT_FRACTION - `NN_FRACTION_BITS;
    localparam int OUT_MAX = (1 << `NN_OUTPUT_SIZE) - 1;

    logic [STEP_W-1:0]                step;
    logic                             running;
    logic                             step_last;
    logic signed [`NN_ACC_SIZE-1:0]   acc;
    logic signed [`NN_INPUT_SIZE:0]   in_sel;
    nn_pkg::weight_t                  w_sel;
    logic signed [`NN_ACC_SIZE-1:0]   prod;
    logic signed [`NN_ACC_SIZE-1:0]   act_shifted;
    nn_pkg::out_val_t                 act_value;

    //////////////////////////////////////////////////
    // MAC datapath
    //////////////////////////////////////////////////

    assign step_last = (step == STEP_W'(`NN_NUM_NEURON));

    // one input and its weight per step
    always_comb begin
        in_sel = $signed({1'b0, inputs[step[IDX_W-1:0]]});
        w_sel  = weights[step[IDX_W-1:0]];
        prod   = in_sel * w_sel;
    end

    // relu, rescale, clip
    always_comb begin
        act_shifted = acc >>> SHIFT;
        if (acc <= 0) begin
            act_value = '0;
        end else if (act_shifted > OUT_MAX) begin
            act_value = '1;
        end else begin
            act_value = act_shifted[`NN_OUTPUT_SIZE-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (running && !step_last) begin
            acc <= acc + prod;
        end
        // result captured once the sum is complete
        if (running && step_last) begin
            out_value <= act_value;
        end
    end

    //////////////////////////////////////////////////
    // step control
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step      <= '0;
            running   <= 1'b0;
            out_valid <= 1'b0;
        end else if (start) begin
            step      <= '0;
            running   <= 1'b1;
            out_valid <= 1'b0;
        end else if (running) begin
            if (step_last) begin
                running   <= 1'b0;
                // held until the next start
                out_valid <= 1'b1;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/neuron_layer.sv
`default_nettype none

`include "nn_cfg.svh"

module neuron_layer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  layer_start,
    input  wire nn_pkg::in_vec_t layer_input,
    input  wire nn_pkg::weight_row_t [`NN_NUM_NEURON-1:0] layer_weights,
    output nn_pkg::out_vec_t     layer_output,
    output logic                 layer_done
);

    // per neuron valid levels
    logic [`NN_NUM_NEURON-1:0] neuron_valid;

    // every neuron sees the same input vector
    // and its own weight row
    genvar g;
    generate
        for (g = 0; g < `NN_NUM_NEURON; g++) begin : g_neuron
            neuron neuron_inst (
                .clk       (clk),
                .rst_n     (rst_n),
                .start     (layer_start),
                .inputs    (layer_input),
                .weights   (layer_weights[g]),
                .out_value (layer_output[g]),
                .out_valid (neuron_valid[g])
            );
        end
    endgenerate

    // full layer in use, so done means all valid
    // drops after the edge that samples layer_start
    assign layer_done = &neuron_valid;

endmodule

`default_nettype wire

// File: verilog/layer_controller.sv
`default_nettype none

`include "nn_cfg.svh"

module layer_controller (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire nn_pkg::in_vec_t    start_input,
    input  wire nn_pkg::layer_idx_t layer_count,
    input  wire nn_pkg::out_vec_t   layer_output,
    input  wire                     layer_done,
    output logic                    layer_start,
    output nn_pkg::in_vec_t         layer_input,
    output nn_pkg::layer_idx_t      layer_idx,
    output nn_pkg::out_vec_t        final_output,
    output logic                    final_output_valid,
    output logic                    busy
);

    // output fraction back up to input fraction
    localparam int RESCALE_SHIFT = `NN_INPUT_FRACTION - `NN_FRACTION_BITS;
    localparam int IN_MAX        = (1 << `NN_INPUT_SIZE) - 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_WAIT
    } state_t;

    state_t             state;
    nn_pkg::in_vec_t    in_reg;
    nn_pkg::layer_idx_t count_reg;
    logic               layer_last;

    // output value to next layer input, clipped
    function automatic nn_pkg::in_val_t rescale(input nn_pkg::out_val_t v);
        logic [`NN_OUTPUT_SIZE+RESCALE_SHIFT-1:0] scaled;
        scaled = {v, {RESCALE_SHIFT{1'b0}}};
        if (scaled > IN_MAX) begin
            return '1;
        end
        return scaled[`NN_INPUT_SIZE-1:0];
    endfunction

    assign layer_input = in_reg;
    assign layer_last  = (layer_idx == nn_pkg::layer_idx_t'(count_reg - 1'b1));

    //////////////////////////////////////////////////
    // layer sequencing FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state              <= ST_IDLE;
            in_reg             <= '0;
            count_reg          <= '0;
            layer_idx          <= '0;
            layer_start        <= 1'b0;
            final_output       <= '0;
            final_output_valid <= 1'b0;
            busy               <= 1'b0;
        end else begin
            // single cycle strobes
            layer_start        <= 1'b0;
            final_output_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // zero layers means nothing to do
                    if (start && (layer_count != '0)) begin
                        in_reg      <= start_input;
                        count_reg   <= layer_count;
                        layer_idx   <= '0;
                        layer_start <= 1'b1;
                        busy        <= 1'b1;
                        state       <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    // layer_done still shows the previous pass here
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (layer_done) begin
                        if (layer_last) begin
                            final_output       <= layer_output;
                            final_output_valid <= 1'b1;
                            busy               <= 1'b0;
                            state              <= ST_IDLE;
                        end else begin
                            for (int n = 0; n < `NN_NUM_NEURON; n++) begin
                                in_reg[n] <= rescale(layer_output[n]);
                            end
                            layer_idx   <= layer_idx + 1'b1;
                            layer_start <= 1'b1;
                            state       <= ST_RUN;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/forward.sv
`default_nettype none

`include "nn_cfg.svh"

module forward (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire nn_pkg::in_vec_t    start_input,
    input  wire nn_pkg::layer_idx_t layer_count,
    input  wire                     w_wr_en,
    input  wire nn_pkg::layer_idx_t w_layer,
    input  wire [1:0]               w_neuron,
    input  wire [1:0]               w_input,
    input  wire nn_pkg::weight_t    w_data,
    output nn_pkg::out_vec_t        final_output,
    output logic                    final_output_valid,
    output logic                    busy
);

    // controller to layer and memory
    logic                 layer_start;
    nn_pkg::in_vec_t      layer_input;
    nn_pkg::layer_idx_t   layer_idx;
    // memory to layer
    nn_pkg::weight_row_t [`NN_NUM_NEURON-1:0] layer_weights;
    // layer back to controller
    nn_pkg::out_vec_t     layer_output;
    logic                 layer_done;

    layer_controller layer_controller_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .start              (start),
        .start_input        (start_input),
        .layer_count        (layer_count),
        .layer_output       (layer_output),
        .layer_done         (layer_done),
        .layer_start        (layer_start),
        .layer_input        (layer_input),
        .layer_idx          (layer_idx),
        .final_output       (final_output),
        .final_output_valid (final_output_valid),
        .busy               (busy)
    );

    weight_memory weight_memory_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .w_wr_en       (w_wr_en),
        .w_layer       (w_layer),
        .w_neuron      (w_neuron),
        .w_input       (w_input),
        .w_data        (w_data),
        .layer_idx     (layer_idx),
        .layer_weights (layer_weights)
    );

    // one physical layer reused for every logical layer
    neuron_layer neuron_layer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .layer_start   (layer_start),
        .layer_input   (layer_input),
        .layer_weights (layer_weights),
        .layer_output  (layer_output),
        .layer_done    (layer_done)
    );

endmodule

`default_nettype wire

// File: verif/forward_tb.sv
`default_nettype none

`include "nn_cfg.svh"

module forward_tb;

    localparam int N       = `NN_NUM_NEURON;
    localparam int TIMEOUT = 200;
    // quiet cycles after a result to catch a stray second job
    localparam int WINDOW  = 40;

    logic               clk;
    logic               rst_n;
    logic               start;
    nn_pkg::in_vec_t    start_input;
    nn_pkg::layer_idx_t layer_count;
    logic               w_wr_en;
    nn_pkg::layer_idx_t w_layer;
    logic [1:0]         w_neuron;
    logic [1:0]         w_input;
    nn_pkg::weight_t    w_data;
    nn_pkg::out_vec_t   final_output;
    logic               final_output_valid;
    logic               busy;

    // shadow copy of every weight written
    nn_pkg::weight_t    w_model [`NN_LAYER_MAX][N][N];
    int                 errors;
    int                 valid_pulses = 0;
    nn_pkg::in_vec_t    vec;

    forward forward_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .start              (start),
        .start_input        (start_input),
        .layer_count        (layer_count),
        .w_wr_en            (w_wr_en),
        .w_layer            (w_layer),
        .w_neuron           (w_neuron),
        .w_input            (w_input),
        .w_data             (w_data),
        .final_output       (final_output),
        .final_output_valid (final_output_valid),
        .busy               (busy)
    );

    always #20 clk = ~clk;

    // counts valid pulses from any job
    always @(posedge clk) begin
        if (final_output_valid) begin
            valid_pulses++;
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAILED %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic write_weight(input int layer, input int neuron, input int inp,
                                input int value);
        @(negedge clk);
        w_wr_en  = 1'b1;
        w_layer  = nn_pkg::layer_idx_t'(layer);
        w_neuron = 2'(neuron);
        w_input  = 2'(inp);
        w_data   = nn_pkg::weight_t'(value);
        w_model[layer][neuron][inp] = nn_pkg::weight_t'(value);
        @(negedge clk);
        w_wr_en = 1'b0;
    endtask

    // reference model of the network one layer at a time
    function automatic nn_pkg::out_vec_t model_forward(input nn_pkg::in_vec_t x,
                                                       input int count);
        nn_pkg::in_vec_t  in_v;
        nn_pkg::out_vec_t out_v;
        longint           sum;
        longint           val;
        in_v  = x;
        out_v = '0;
        for (int l = 0; l < count; l++) begin
            for (int n = 0; n < N; n++) begin
                sum = 0;
                for (int i = 0; i < N; i++) begin
                    sum += longint'(in_v[i]) * longint'(w_model[l][n][i]);
                end
                // relu then 16 fraction bits down to 6
                val = (sum <= 0) ? 0 : (sum >> 10);
                if (val > 1023) begin
                    val = 1023;
                end
                out_v[n] = nn_pkg::out_val_t'(val);
            end
            // next layer input is output times 4 clipped to 511
            for (int n = 0; n < N; n++) begin
                val = longint'(out_v[n]) * 4;
                if (val > 511) begin
                    val = 511;
                end
                in_v[n] = nn_pkg::in_val_t'(val);
            end
        end
        return out_v;
    endfunction

    task automatic run_network(input string name, input nn_pkg::in_vec_t x, input int count,
                               input bit restart);
        nn_pkg::out_vec_t expected;
        int               cycles;
        int               pulses_before;
        expected      = model_forward(x, count);
        pulses_before = valid_pulses;
        @(negedge clk);
        start       = 1'b1;
        start_input = x;
        layer_count = nn_pkg::layer_idx_t'(count);
        @(negedge clk);
        start = 1'b0;
        check_value({name, " busy"}, 1, int'(busy));
        cycles = 0;
        while (!final_output_valid && cycles < TIMEOUT) begin
            // optional second start in the middle of the job
            start       = restart && (cycles == 3);
            start_input = ~x;
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        if (!final_output_valid) begin
            $display("%s: final_output_valid did not rise within %0d cycles", name, TIMEOUT);
            errors++;
        end else begin
            for (int n = 0; n < N; n++) begin
                check_value($sformatf("%s output %0d", name, n), int'(expected[n]),
                            int'(final_output[n]));
            end
            // busy falls with the valid pulse
            check_value({name, " busy at valid"}, 0, int'(busy));
        end
        repeat (WINDOW) @(negedge clk);
        check_value({name, " valid pulses"}, 1, valid_pulses - pulses_before);
    endtask

    task automatic start_ignored(input string name);
        int cycles;
        int pulses_before;
        pulses_before = valid_pulses;
        @(negedge clk);
        start       = 1'b1;
        start_input = '1;
        layer_count = '0;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        while (!busy && !final_output_valid && cycles < WINDOW) begin
            @(negedge clk);
            cycles++;
        end
        check_value({name, " busy"}, 0, int'(busy));
        check_value({name, " valid pulses"}, 0, valid_pulses - pulses_before);
    endtask

    task automatic random_input(output nn_pkg::in_vec_t x);
        for (int n = 0; n < N; n++) begin
            x[n] = nn_pkg::in_val_t'($urandom_range(0, 511));
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        start_input = '0;
        layer_count = '0;
        w_wr_en     = 1'b0;
        w_layer     = '0;
        w_neuron    = '0;
        w_input     = '0;
        w_data      = '0;
        errors      = 0;
        void'($urandom(51271));
        for (int l = 0; l < `NN_LAYER_MAX; l++) begin
            for (int n = 0; n < N; n++) begin
                for (int i = 0; i < N; i++) begin
                    w_model[l][n][i] = '0;
                end
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // reset state
        check_value("reset busy", 0, int'(busy));
        check_value("reset valid", 0, int'(final_output_valid));
        check_value("reset output", 0, int'(final_output != '0));

        // one layer with 1.0 on the diagonal gives input / 4
        for (int n = 0; n < N; n++) begin
            write_weight(0, n, n, 256);
        end
        vec = {9'd511, 9'd3, 9'd255, 9'd400};
        run_network("identity", vec, 1, 1'b0);
        check_value("identity lane 0", 100, int'(final_output[0]));

        // own random matrix per layer
        for (int l = 0; l < `NN_LAYER_MAX; l++) begin
            for (int n = 0; n < N; n++) begin
                for (int i = 0; i < N; i++) begin
                    write_weight(l, n, i, int'($urandom_range(0, 1023)) - 512);
                end
            end
        end
        for (int k = 0; k < 4; k++) begin
            random_input(vec);
            run_network($sformatf("random 3 layers %0d", k), vec, 3, 1'b0);
            random_input(vec);
            run_network($sformatf("random 2 layers %0d", k), vec, 2, 1'b0);
        end

        // negative weights clamp to zero
        for (int n = 0; n < N; n++) begin
            for (int i = 0; i < N; i++) begin
                write_weight(0, n, i, -256);
            end
        end
        vec = '1;
        run_network("relu", vec, 1, 1'b0);
        check_value("relu lane 0", 0, int'(final_output[0]));

        // largest weight saturates the first layer
        // 4.0 on the second layer diagonal passes its clipped 511 through
        for (int n = 0; n < N; n++) begin
            for (int i = 0; i < N; i++) begin
                write_weight(0, n, i, 65535);
                write_weight(1, n, i, (n == i) ? 1024 : 0);
            end
        end
        run_network("saturate", vec, 1, 1'b0);
        check_value("saturate lane 0", 1023, int'(final_output[0]));
        run_network("clip input", vec, 2, 1'b0);
        check_value("clip input lane 0", 511, int'(final_output[0]));

        // starts that must be ignored
        start_ignored("zero layers");
        random_input(vec);
        run_network("start while busy", vec, 3, 1'b1);

        $display("errors: %0d, valid pulses: %0d", errors, valid_pulses);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+verilog
verilog/nn_pkg.sv
verilog/weight_memory.sv
verilog/neuron.sv
verilog/neuron_layer.sv
verilog/layer_controller.sv
verilog/forward.sv
verif/forward_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the forward testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module forward_tb -o forward_tb_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/forward_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi
exit 0
